/* Makefile */
# Verilator build and run of the mixer testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --assert --timing -Wno-fatal -f src.f \
		--top-module tb_audio_mixer -Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then exit 1; fi
	@grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* audio_channel_play.sv */
/*
 * per-channel playback: period counters, sample word buffers,
 * high then low byte sequencing
 */
`timescale 1ns/1ps
`default_nettype none

`include "audio_mixer_consts.svh"

module audio_channel_play (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       audio_enable_i,
    input  wire logic [`AUD_NCHAN-1:0]      restart_i,
    input  audio_mixer_pkg::chan_cfg_t      chan_cfg_i [`AUD_NCHAN],
    input  audio_mixer_pkg::dma_word_t      sample_word_i,
    output logic [`AUD_NCHAN-1:0]           buf_empty_o,
    output audio_mixer_pkg::sample_t        sample_o [`AUD_NCHAN]
);
    import audio_mixer_pkg::*;

    logic [`AUD_PER_W:0]    per_cnt [`AUD_NCHAN];   // top bit is underflow
    word_t                  buf_word [`AUD_NCHAN];
    logic [`AUD_NCHAN-1:0]  buf_full;
    logic [`AUD_NCHAN-1:0]  buf_odd;                // low byte is next

    assign buf_empty_o = ~buf_full;

    always_ff @(posedge clk) begin
        for (int i = 0; i < `AUD_NCHAN; i++) begin
            if (sample_word_i.valid && sample_word_i.chan == chan_t'(i)) begin
                buf_word[i] <= sample_word_i.word;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            buf_full <= '0;
            buf_odd  <= '0;
            for (int i = 0; i < `AUD_NCHAN; i++) begin
                per_cnt[i]  <= '0;
                sample_o[i] <= '0;              // silence into mixer
            end
        end else begin
            for (int i = 0; i < `AUD_NCHAN; i++) begin
                per_cnt[i] <= per_cnt[i] - 1'b1;
                if (per_cnt[i][`AUD_PER_W]) begin
                    per_cnt[i] <= {1'b0, chan_cfg_i[i].period};
                    if (buf_full[i]) begin      // else hold last sample
                        sample_o[i] <= buf_odd[i] ? buf_word[i][7:0] : buf_word[i][15:8];
                        buf_odd[i]  <= ~buf_odd[i];
                        if (buf_odd[i]) begin
                            buf_full[i] <= 1'b0;    // word used up
                        end
                    end
                end
                if (sample_word_i.valid && sample_word_i.chan == chan_t'(i)) begin
                    buf_full[i] <= 1'b1;
                end
                if (restart_i[i] || !audio_enable_i) begin
                    buf_full[i] <= 1'b0;        // drop word, restart at high byte
                    buf_odd[i]  <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* audio_mix_accum.sv */
/*
 * channel mixer: 6-cycle frame sequencer, operand register,
 * signed multiply-accumulate, clamp and unsigned output
 */
`timescale 1ns/1ps
`default_nettype none

`include "audio_mixer_consts.svh"

module audio_mix_accum (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  audio_mixer_pkg::chan_cfg_t      chan_cfg_i [`AUD_NCHAN],
    input  audio_mixer_pkg::sample_t        sample_i [`AUD_NCHAN],
    output audio_mixer_pkg::dac_t           mix_l_o,
    output audio_mixer_pkg::dac_t           mix_r_o,
    output logic                            mix_valid_o
);
    import audio_mixer_pkg::*;

    localparam int LAST_STEP = `AUD_NCHAN + 1;  // clamp and output step

    logic [`AUD_CHAN_W:0]           step;           // 0..NCHAN+1
    sample_t                        op_samp;        // stage 1 operands
    logic signed [`AUD_VOL_W:0]     op_vol_l;
    logic signed [`AUD_VOL_W:0]     op_vol_r;
    acc_t                           prod_l;
    acc_t                           prod_r;
    acc_t                           acc_l;
    acc_t                           acc_r;

    // saturate to signed 8 bits then flip sign for unsigned output
    function automatic dac_t clamp_u8(input logic signed [15-`AUD_ACC_LSB:0] v);
        if (v < -128) begin
            return 8'h00;
        end else if (v > 127) begin
            return 8'hFF;
        end
        return v[7:0] ^ 8'h80;
    endfunction

    assign prod_l = op_samp * op_vol_l;         // signed x zero-extended volume
    assign prod_r = op_samp * op_vol_r;

    always_ff @(posedge clk) begin
        if (step < `AUD_NCHAN) begin
            op_samp  <= sample_i[step[`AUD_CHAN_W-1:0]];
            op_vol_l <= {1'b0, chan_cfg_i[step[`AUD_CHAN_W-1:0]].vol_l};
            op_vol_r <= {1'b0, chan_cfg_i[step[`AUD_CHAN_W-1:0]].vol_r};
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            step        <= '0;
            acc_l       <= '0;
            acc_r       <= '0;
            mix_l_o     <= 8'h80;               // midscale silence
            mix_r_o     <= 8'h80;
            mix_valid_o <= 1'b0;
        end else begin
            mix_valid_o <= 1'b0;
            step        <= step + 1'b1;
            if (step == LAST_STEP) begin
                step        <= '0;
                acc_l       <= '0;
                acc_r       <= '0;
                mix_l_o     <= clamp_u8(acc_l[15:`AUD_ACC_LSB]);
                mix_r_o     <= clamp_u8(acc_r[15:`AUD_ACC_LSB]);
                mix_valid_o <= 1'b1;
            end else if (step != 0) begin   // operands of step-1 ready
                acc_l <= acc_l + prod_l;
                acc_r <= acc_r + prod_r;
            end
        end
    end

endmodule

`default_nettype wire

/* audio_mixer_consts.svh */
/*
 * mixer constants: channel count, register indices,
 * output/volume/period widths, accumulator slice position
 */
`ifndef AUDIO_MIXER_CONSTS_SVH
`define AUDIO_MIXER_CONSTS_SVH

`define AUD_NCHAN       4       // number of playback channels
`define AUD_CHAN_W      2       // channel index bits
`define AUD_DAC_W       8       // mixed output bits
`define AUD_VOL_W       7       // per-channel volume bits
`define AUD_PER_W       15      // period reload bits
`define AUD_REG_START   0       // START register index
`define AUD_REG_LENGTH  1       // LENGTH register index
`define AUD_ACC_LSB     6       // lowest accumulator bit kept

`endif

/* audio_mixer_pkg.sv */
/*
 * shared mixer types: data widths, channel config struct,
 * parameter RAM write, DMA word and fetch FSM states
 */
`default_nettype none

`include "audio_mixer_consts.svh"

package audio_mixer_pkg;

    typedef logic [15:0]                word_t;         // RAM and DMA data
    typedef logic [15:0]                addr_t;         // DMA sample address
    typedef logic [`AUD_CHAN_W-1:0]     chan_t;
    typedef logic signed [7:0]          sample_t;
    typedef logic [`AUD_VOL_W-1:0]      vol_t;
    typedef logic [`AUD_PER_W-1:0]      period_t;
    typedef logic [`AUD_CHAN_W+1:0]     pmem_addr_t;    // {bank, chan, reg}
    typedef logic [`AUD_CHAN_W:0]       reg_addr_t;     // {chan, reg}
    typedef logic [`AUD_DAC_W-1:0]      dac_t;          // unsigned output
    typedef logic signed [15:0]         acc_t;

    typedef struct packed {
        vol_t    vol_l;
        vol_t    vol_r;
        period_t period;
    } chan_cfg_t;                                       // live channel controls

    typedef struct packed {
        logic       en;
        pmem_addr_t addr;
        word_t      data;
    } pmem_wr_t;                                        // fetch write port

    typedef struct packed {
        logic  valid;
        chan_t chan;
        word_t word;
    } dma_word_t;                                       // acked word to playback

    typedef enum logic [2:0] {
        FETCH_CHECK,
        FETCH_RD_PTR,
        FETCH_DEC_LEN,
        FETCH_RELOAD,
        FETCH_SET_LEN,
        FETCH_REQ,
        FETCH_WAIT_ACK
    } fetch_state_t;

endpackage

`default_nettype wire

/* audio_mixer_stim.txt */
// word 0: record count; each record: mode (0 mix, 1 byte order, 2 restart),
// then per channel: start length vol_l vol_r period word, then exp_l exp_r
0004
// record 1: mixed levels, ch2 run of one word
0000
000A 0003 0028 000A 001F 3030
0014 0002 0014 0032 0021 E0E0
001E 0000 0008 0008 0023 5050
0028 0005 0000 001E 0025 9C9C
009E 0049
// record 2: saturation high left, low right
0000
0064 0001 007F 007F 0028 7F7F
006E 0003 007F 0000 002A 7F7F
0078 0000 0000 007F 002C 8080
0082 0001 0000 007F 002E 8080
00FF 0000
// record 3: byte order on ch0, exp is high then low byte
0001
008C 0003 0040 0040 0014 4010
0096 0000 0000 0000 0030 1111
00A0 0000 0000 0000 0032 2222
00AA 0000 0000 0000 0034 3333
00C0 0090
// record 4: ch1 restart mid run
0002
0032 0001 001E 001E 0021 1818
003C 0007 003C 000A 0023 F0F0
0046 0002 0010 0010 0025 0C0C
0050 0003 0032 0032 0027 0000
007F 008B

/* audio_mixer_top.sv */
/*
 * mixer top level: parameter RAM, sample fetch,
 * channel playback and mix accumulator
 */
`timescale 1ns/1ps
`default_nettype none

`include "audio_mixer_consts.svh"

module audio_mixer_top (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       audio_enable_i,
    input  wire logic                       reg_wr_i,
    input  audio_mixer_pkg::reg_addr_t      reg_addr_i,
    input  audio_mixer_pkg::word_t          reg_data_i,
    input  audio_mixer_pkg::chan_cfg_t      chan_cfg_i [`AUD_NCHAN],
    input  wire logic [`AUD_NCHAN-1:0]      restart_i,
    output logic [`AUD_NCHAN-1:0]           reload_o,
    output logic                            dma_req_o,
    output audio_mixer_pkg::addr_t          dma_addr_o,
    input  wire logic                       dma_ack_i,
    input  audio_mixer_pkg::word_t          dma_word_i,
    output audio_mixer_pkg::dac_t           mix_l_o,
    output audio_mixer_pkg::dac_t           mix_r_o,
    output logic                            mix_valid_o
);
    import audio_mixer_pkg::*;

    pmem_addr_t             rd_addr;
    word_t                  rd_data;
    pmem_wr_t               pmem_wr;            // fetch write-back
    logic [`AUD_NCHAN-1:0]  buf_empty;
    dma_word_t              sample_word;        // acked word to buffers
    sample_t                samples [`AUD_NCHAN];

    audio_param_mem u_param_mem (
        .clk(clk),
        .reset_i(reset_i),
        .reg_wr_i(reg_wr_i),
        .reg_addr_i(reg_addr_i),
        .reg_data_i(reg_data_i),
        .fetch_wr_i(pmem_wr),
        .rd_addr_i(rd_addr),
        .rd_data_o(rd_data)
    );

    audio_sample_fetch u_fetch (
        .clk(clk),
        .reset_i(reset_i),
        .audio_enable_i(audio_enable_i),
        .restart_i(restart_i),
        .buf_empty_i(buf_empty),
        .rd_addr_o(rd_addr),
        .rd_data_i(rd_data),
        .pmem_wr_o(pmem_wr),
        .reload_o(reload_o),
        .dma_req_o(dma_req_o),
        .dma_addr_o(dma_addr_o),
        .dma_ack_i(dma_ack_i),
        .dma_word_i(dma_word_i),
        .sample_word_o(sample_word)
    );

    audio_channel_play u_play (
        .clk(clk),
        .reset_i(reset_i),
        .audio_enable_i(audio_enable_i),
        .restart_i(restart_i),
        .chan_cfg_i(chan_cfg_i),
        .sample_word_i(sample_word),
        .buf_empty_o(buf_empty),
        .sample_o(samples)
    );

    audio_mix_accum u_mix (
        .clk(clk),
        .reset_i(reset_i),
        .chan_cfg_i(chan_cfg_i),
        .sample_i(samples),
        .mix_l_o(mix_l_o),
        .mix_r_o(mix_r_o),
        .mix_valid_o(mix_valid_o)
    );

endmodule

`default_nettype wire

/* audio_param_mem.sv */
/*
 * host register write latch, write arbitration (fetch first)
 * and 16-word parameter RAM with registered read
 */
`timescale 1ns/1ps
`default_nettype none

module audio_param_mem (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       reg_wr_i,
    input  audio_mixer_pkg::reg_addr_t      reg_addr_i,
    input  audio_mixer_pkg::word_t          reg_data_i,
    input  audio_mixer_pkg::pmem_wr_t       fetch_wr_i,
    input  audio_mixer_pkg::pmem_addr_t     rd_addr_i,
    output audio_mixer_pkg::word_t          rd_data_o
);
    import audio_mixer_pkg::*;

    logic           host_pend;                  // latched host write waiting
    reg_addr_t      host_addr;
    word_t          host_data;
    logic           mem_we;
    pmem_addr_t     mem_waddr;
    word_t          mem_wdata;
    word_t          mem [16];                   // banks 0 host, 1 working

    always_ff @(posedge clk) begin
        if (reset_i) begin
            host_pend <= 1'b0;
        end else if (reg_wr_i) begin
            host_pend <= 1'b1;                  // newest write wins
        end else if (!fetch_wr_i.en) begin
            host_pend <= 1'b0;                  // free slot, written now
        end
    end

    always_ff @(posedge clk) begin
        if (reg_wr_i) begin
            host_addr <= reg_addr_i;
            host_data <= reg_data_i;
        end
    end

    always_comb begin
        mem_we    = fetch_wr_i.en | host_pend;
        mem_waddr = fetch_wr_i.addr;            // fetch has priority
        mem_wdata = fetch_wr_i.data;
        if (!fetch_wr_i.en) begin
            mem_waddr = {1'b0, host_addr};      // host regs live in bank 0
            mem_wdata = host_data;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
        rd_data_o <= mem[rd_addr_i];            // one cycle read
    end

endmodule

`default_nettype wire

/* audio_sample_fetch.sv */
/*
 * sample fetch FSM: priority scan of empty channels,
 * working count/pointer update, reload and DMA request
 */
`timescale 1ns/1ps
`default_nettype none

`include "audio_mixer_consts.svh"

module audio_sample_fetch (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       audio_enable_i,
    input  wire logic [`AUD_NCHAN-1:0]      restart_i,
    input  wire logic [`AUD_NCHAN-1:0]      buf_empty_i,
    output audio_mixer_pkg::pmem_addr_t     rd_addr_o,
    input  audio_mixer_pkg::word_t          rd_data_i,
    output audio_mixer_pkg::pmem_wr_t       pmem_wr_o,
    output logic [`AUD_NCHAN-1:0]           reload_o,
    output logic                            dma_req_o,
    output audio_mixer_pkg::addr_t          dma_addr_o,
    input  wire logic                       dma_ack_i,
    input  audio_mixer_pkg::word_t          dma_word_i,
    output audio_mixer_pkg::dma_word_t      sample_word_o
);
    import audio_mixer_pkg::*;

    fetch_state_t           state;
    chan_t                  fetch_chan;         // channel being serviced
    logic [`AUD_NCHAN-1:0]  restart_pend;       // forces reload on next fetch
    logic                   scan_hit;
    chan_t                  scan_chan;
    logic [16:0]            len_dec;            // bit 16 flags underflow

    // parameter RAM address for a bank, channel and register
    function automatic pmem_addr_t pm_addr(input logic bank, input chan_t ch, input int idx);
        return {bank, ch, 1'(idx)};
    endfunction

    // lowest numbered empty buffer wins
    always_comb begin
        scan_hit  = 1'b0;
        scan_chan = '0;
        for (int i = `AUD_NCHAN-1; i >= 0; i--) begin
            if (buf_empty_i[i]) begin
                scan_hit  = 1'b1;
                scan_chan = chan_t'(i);
            end
        end
    end

    assign len_dec = {1'b0, rd_data_i} - 17'd1;

    // acked word goes straight to playback, buffer fills at the ack edge
    assign sample_word_o.valid = (state == FETCH_WAIT_ACK) && dma_ack_i;
    assign sample_word_o.chan  = fetch_chan;
    assign sample_word_o.word  = dma_word_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state        <= FETCH_CHECK;
            fetch_chan   <= '0;
            rd_addr_o    <= '0;
            pmem_wr_o    <= '0;
            reload_o     <= '0;
            dma_req_o    <= 1'b0;
            dma_addr_o   <= '0;
            restart_pend <= '1;                 // working regs unknown
        end else begin
            reload_o     <= '0;                 // single cycle pulses
            pmem_wr_o.en <= 1'b0;
            case (state)
                FETCH_CHECK: begin
                    if (audio_enable_i && scan_hit) begin
                        fetch_chan <= scan_chan;
                        rd_addr_o  <= pm_addr(1'b1, scan_chan, `AUD_REG_LENGTH);
                        state      <= FETCH_RD_PTR;
                    end
                end
                FETCH_RD_PTR: begin             // count read in flight
                    rd_addr_o <= pm_addr(1'b1, fetch_chan, `AUD_REG_START);
                    state     <= FETCH_DEC_LEN;
                end
                FETCH_DEC_LEN: begin            // count on rd_data
                    pmem_wr_o.en   <= 1'b1;
                    pmem_wr_o.addr <= pm_addr(1'b1, fetch_chan, `AUD_REG_LENGTH);
                    pmem_wr_o.data <= len_dec[15:0];
                    if (len_dec[16] || restart_pend[fetch_chan]) begin
                        rd_addr_o <= pm_addr(1'b0, fetch_chan, `AUD_REG_LENGTH);
                        state     <= FETCH_RELOAD;
                    end else begin
                        state     <= FETCH_REQ;
                    end
                    restart_pend[fetch_chan] <= 1'b0;
                end
                FETCH_RELOAD: begin             // pointer read discarded
                    rd_addr_o <= pm_addr(1'b0, fetch_chan, `AUD_REG_START);
                    state     <= FETCH_SET_LEN;
                end
                FETCH_SET_LEN: begin            // LENGTH on rd_data
                    pmem_wr_o.en         <= 1'b1;
                    pmem_wr_o.addr       <= pm_addr(1'b1, fetch_chan, `AUD_REG_LENGTH);
                    pmem_wr_o.data       <= rd_data_i;
                    reload_o[fetch_chan] <= 1'b1;
                    state                <= FETCH_REQ;
                end
                FETCH_REQ: begin                // pointer or START on rd_data
                    pmem_wr_o.en   <= 1'b1;
                    pmem_wr_o.addr <= pm_addr(1'b1, fetch_chan, `AUD_REG_START);
                    pmem_wr_o.data <= rd_data_i + 16'd1;
                    dma_req_o      <= 1'b1;
                    dma_addr_o     <= rd_data_i;
                    state          <= FETCH_WAIT_ACK;
                end
                FETCH_WAIT_ACK: begin
                    if (dma_ack_i) begin
                        dma_req_o <= 1'b0;
                        state     <= FETCH_CHECK;
                    end
                end
                default: state <= FETCH_CHECK;
            endcase

            for (int i = 0; i < `AUD_NCHAN; i++) begin
                if (restart_i[i] || !audio_enable_i) begin
                    restart_pend[i] <= 1'b1;    // beats the clear above
                end
            end
            if (!audio_enable_i) begin          // idle and abort request
                state     <= FETCH_CHECK;
                dma_req_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
audio_mixer_pkg.sv
audio_param_mem.sv
audio_sample_fetch.sv
audio_channel_play.sv
audio_mix_accum.sv
audio_mixer_top.sv
tb_audio_mixer_asserts.sv
tb_audio_mixer.sv

/* tb_audio_mixer.sv */
/*
 * mixer testbench: clock, reset, stim record reader, DMA memory model,
 * address/reload tracking, mix model and final report
 */
`timescale 1ns/1ps
`default_nettype none

`include "audio_mixer_consts.svh"

module tb_audio_mixer;
    import audio_mixer_pkg::*;

    localparam int REC_W = 27;                  // mode, 4 x 6 channel words, 2 expected

    logic                   clk;
    logic                   reset_i;
    logic                   audio_enable_i;
    logic                   reg_wr_i;
    reg_addr_t              reg_addr_i;
    word_t                  reg_data_i;
    chan_cfg_t              chan_cfg [`AUD_NCHAN];
    logic [`AUD_NCHAN-1:0]  restart_i;
    logic [`AUD_NCHAN-1:0]  reload_o;
    logic                   dma_req_o;
    addr_t                  dma_addr_o;
    logic                   dma_ack_i;
    word_t                  dma_word_i;
    dac_t                   mix_l_o;
    dac_t                   mix_r_o;
    logic                   mix_valid_o;

    logic [15:0]            stim [0:255];       // raw stim words
    word_t                  dma_mem [0:255];    // sample memory seen by DMA
    int                     start_a [`AUD_NCHAN];
    int                     len_a [`AUD_NCHAN];
    int                     exp_addr [`AUD_NCHAN]; // next address per channel
    int                     req_cnt [`AUD_NCHAN];
    logic [`AUD_NCHAN-1:0]  reload_seen;        // pulse since last request
    int                     errors;
    int                     checks;
    logic                   restart_armed;
    logic                   restart_done;
    logic                   order_on;
    logic                   order_started;
    int                     alt_cnt;
    dac_t                   got_l;
    dac_t                   got_r;
    dac_t                   prev_l;
    dac_t                   hi_exp;
    dac_t                   lo_exp;

    always #20 clk = ~clk;                      // 40 ns period

    audio_mixer_top UUT (
        .clk(clk), .reset_i(reset_i), .audio_enable_i(audio_enable_i),
        .reg_wr_i(reg_wr_i), .reg_addr_i(reg_addr_i), .reg_data_i(reg_data_i),
        .chan_cfg_i(chan_cfg), .restart_i(restart_i), .reload_o(reload_o),
        .dma_req_o(dma_req_o), .dma_addr_o(dma_addr_o), .dma_ack_i(dma_ack_i),
        .dma_word_i(dma_word_i), .mix_l_o(mix_l_o), .mix_r_o(mix_r_o),
        .mix_valid_o(mix_valid_o)
    );

    task automatic check_value(input string name, input int exp_v, input int act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("FAIL %s: expected %0h, actual %0h", name, exp_v, act_v);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;                                     // drive point after the edge
    endtask

    // which channel's run holds this address, -1 if none
    function automatic int chan_of(input int addr);
        for (int c = 0; c < `AUD_NCHAN; c++) begin
            if (addr >= start_a[c] && addr <= start_a[c] + len_a[c]) begin
                return c;
            end
        end
        return -1;
    endfunction

    // acc >>> 6, saturate to signed byte, flip sign bit
    function automatic int mix_model(input int acc);
        int v;
        v = acc >>> 6;
        if (v < -128) v = -128;
        if (v > 127) v = 127;
        return (v & 'hFF) ^ 'h80;
    endfunction

    task automatic write_reg(input int ch, input int idx, input int val);
        reg_wr_i   = 1'b1;
        reg_addr_i = reg_addr_t'({2'(ch), 1'(idx)});
        reg_data_i = word_t'(val);
        next_cycle();
        reg_wr_i   = 1'b0;
        next_cycle();                           // free slot for the latched write
    endtask

    // count n frames, keep last values, follow byte order when enabled
    task automatic wait_frames(input int n);
        int cnt;
        int cyc;
        cnt = 0;
        cyc = 0;
        while (cnt < n && cyc < n * 6 + 100) begin
            @(posedge clk);
            cyc++;
            if (mix_valid_o) begin
                cnt++;
                got_l = mix_l_o;
                got_r = mix_r_o;
                if (order_on && !order_started &&
                    (got_l == hi_exp || got_l == lo_exp)) begin
                    check_value("first byte played", hi_exp, got_l);   // high byte leads
                    order_started = 1'b1;
                    prev_l        = got_l;
                end else if (order_on && order_started && got_l != prev_l) begin
                    check_value("byte order", (prev_l == hi_exp) ? lo_exp : hi_exp, got_l);
                    prev_l = got_l;
                    alt_cnt++;
                end
            end
        end
        #2;
        if (cnt < n) begin
            errors++;
            $display("ERROR: timed out waiting for mix frames, got %0d of %0d", cnt, n);
        end
    endtask

    task automatic run_record(input int b);
        int base;
        int mode;
        int sum_l;
        int sum_r;
        int sum_lo;
        mode  = stim[b];
        sum_l = 0;
        sum_r = 0;
        sum_lo = 0;
        audio_enable_i = 1'b0;                  // idle fetch, force reloads
        repeat (4) next_cycle();
        for (int ch = 0; ch < `AUD_NCHAN; ch++) begin
            base               = b + 1 + ch * 6;
            start_a[ch]        = stim[base];
            len_a[ch]          = stim[base+1];
            chan_cfg[ch].vol_l = vol_t'(stim[base+2]);
            chan_cfg[ch].vol_r = vol_t'(stim[base+3]);
            chan_cfg[ch].period = period_t'(stim[base+4]);
            for (int a = start_a[ch]; a <= start_a[ch] + len_a[ch]; a++) begin
                dma_mem[a & 255] = stim[base+5];
            end
            exp_addr[ch]    = start_a[ch];
            reload_seen[ch] = 1'b0;
            req_cnt[ch]     = 0;
            sum_l  += int'($signed(stim[base+5][15:8])) * int'(stim[base+2]);
            sum_r  += int'($signed(stim[base+5][15:8])) * int'(stim[base+3]);
            sum_lo += int'($signed(stim[base+5][7:0])) * int'(stim[base+2]);
            write_reg(ch, `AUD_REG_START, start_a[ch]);
            write_reg(ch, `AUD_REG_LENGTH, len_a[ch]);
        end
        hi_exp = dac_t'(stim[b+25]);
        lo_exp = dac_t'(stim[b+26]);
        check_value("stim left vs model", stim[b+25], mix_model(sum_l));
        check_value("stim right vs model", stim[b+26], mix_model(mode == 1 ? sum_lo : sum_r));
        restart_armed  = (mode == 2);
        restart_done   = 1'b0;
        order_on       = (mode == 1);
        order_started  = 1'b0;
        alt_cnt        = 0;
        audio_enable_i = 1'b1;
        wait_frames(200);
        if (mode == 1) begin
            check_value("byte order alternations", 1, alt_cnt >= 4);
        end else begin
            check_value($sformatf("record at %0d mix_l", b), stim[b+25], got_l);
            check_value($sformatf("record at %0d mix_r", b), stim[b+26], got_r);
        end
        if (mode == 2) begin
            check_value("restart issued", 1, restart_done);
        end
        for (int ch = 0; ch < `AUD_NCHAN; ch++) begin
            check_value($sformatf("run wrapped ch%0d", ch), 1, req_cnt[ch] > len_a[ch] + 1);
        end
    endtask

    always @(posedge clk) begin
        for (int c = 0; c < `AUD_NCHAN; c++) begin
            if (reload_o[c]) reload_seen[c] = 1'b1;
        end
    end

    // DMA slave tracks the address sequence and acks after 1 to 4 cycles
    always begin : dma_model
        int c;
        int addr;
        int delay;
        @(posedge clk);
        if (dma_req_o) begin
            addr = int'(dma_addr_o);
            c    = chan_of(addr);
            if (c < 0) begin
                errors++;
                $display("ERROR: DMA address %0h lies outside every sample run", addr);
            end else begin
                check_value($sformatf("dma address ch%0d", c), exp_addr[c], addr);
                check_value($sformatf("reload at wrap ch%0d", c), addr == start_a[c],
                            reload_seen[c]);
                reload_seen[c] = 1'b0;
                req_cnt[c]++;
                exp_addr[c] = (addr >= start_a[c] + len_a[c]) ? start_a[c] : addr + 1;
                if (restart_armed && c != 1 && exp_addr[1] > start_a[1] + 1) begin
                    #2 restart_i[1] = 1'b1;     // ch1 mid run, not in flight
                    @(posedge clk);
                    #2 restart_i = '0;
                    exp_addr[1]   = start_a[1];
                    restart_armed = 1'b0;
                    restart_done  = 1'b1;
                end
            end
            delay = $urandom % 4;
            repeat (delay) @(posedge clk);
            #2;
            if (dma_req_o) begin                // skip aborted requests
                dma_ack_i  = 1'b1;
                dma_word_i = dma_mem[addr & 255];
                @(posedge clk);
                #2 dma_ack_i = 1'b0;
            end
        end
    end

    initial begin
        void'($urandom(95814));
        clk            = 1'b0;
        reset_i        = 1'b1;
        audio_enable_i = 1'b0;
        reg_wr_i       = 1'b0;
        reg_addr_i     = '0;
        reg_data_i     = '0;
        restart_i      = '0;
        dma_ack_i      = 1'b0;
        dma_word_i     = '0;
        errors         = 0;
        checks         = 0;
        reload_seen    = '0;
        restart_armed  = 1'b0;
        order_on       = 1'b0;
        for (int c = 0; c < `AUD_NCHAN; c++) begin
            chan_cfg[c] = '0;
            start_a[c]  = 0;
            len_a[c]    = -1;                   // no run yet
        end
        for (int a = 0; a < 256; a++) begin
            dma_mem[a] = word_t'({a[7:0], ~a[7:0]});
        end
        $readmemh("audio_mixer_stim.txt", stim);
        repeat (10) @(posedge clk);
        #2 reset_i = 1'b0;
        @(posedge clk);
        check_value("reset mix_l", 'h80, mix_l_o);
        check_value("reset mix_r", 'h80, mix_r_o);
        repeat (20) begin
            @(posedge clk);
            check_value("dma_req while disabled", 0, dma_req_o);
            check_value("reload while disabled", 0, reload_o);
        end
        #2;
        for (int r = 0; r < stim[0]; r++) begin
            run_record(1 + r * REC_W);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_audio_mixer_asserts.sv */
/*
 * concurrent checks on mixer top ports: request vs enable,
 * address hold, reload one-hot, mix strobe spacing
 */
`timescale 1ns/1ps
`default_nettype none

module tb_audio_mixer_asserts (
    input wire logic        clk,
    input wire logic        reset_i,
    input wire logic        audio_enable_i,
    input wire logic        dma_req_o,
    input wire logic [15:0] dma_addr_o,
    input wire logic [3:0]  reload_o,
    input wire logic        mix_valid_o
);

    req_off_when_disabled: assert property (@(posedge clk) disable iff (reset_i)
        !audio_enable_i |=> !dma_req_o)
        else $error("dma request while audio disabled");

    addr_hold: assert property (@(posedge clk) disable iff (reset_i)
        dma_req_o && $past(dma_req_o) |-> $stable(dma_addr_o))
        else $error("dma address moved during request");

    reload_onehot: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(reload_o))
        else $error("more than one reload bit set");

    mix_strobe_single: assert property (@(posedge clk) disable iff (reset_i)
        mix_valid_o |=> !mix_valid_o)
        else $error("mix valid high two cycles running");

endmodule

bind audio_mixer_top tb_audio_mixer_asserts u_asserts (
    .clk(clk), .reset_i(reset_i), .audio_enable_i(audio_enable_i),
    .dma_req_o(dma_req_o), .dma_addr_o(dma_addr_o),
    .reload_o(reload_o), .mix_valid_o(mix_valid_o)
);

`default_nettype wire
